//--- Bender.yml
package:
  name: alu_issue

dependencies: {}

sources:
  # design, in compile order
  - files:
      - rtl/alu_issue_pkg.sv
      - rtl/issue_if.sv
      - rtl/cdb_if.sv
      - rtl/psel_gen.sv
      - rtl/rs_alu.sv
      - rtl/alu_exec.sv
      - rtl/cdb_arb.sv
      - rtl/alu_issue_top.sv
  # testbench
  - target: test
    files:
      - verification/tb_alu_issue.sv

//--- list.f
rtl/alu_issue_pkg.sv
rtl/issue_if.sv
rtl/cdb_if.sv
rtl/psel_gen.sv
rtl/rs_alu.sv
rtl/alu_exec.sv
rtl/cdb_arb.sv
rtl/alu_issue_top.sv
verification/tb_alu_issue.sv

//--- rtl/alu_exec.sv
////////////////////
// single-cycle integer alu
// result register held until the cdb takes it
////////////////////
`timescale 1ns/1ns

module alu_exec (
    input  logic clock,
    input  logic reset,
    input  logic flush,
    issue_if.alu issue,
    cdb_if.src   result,
    input  logic alu_grant     // arbiter took the result this cycle
);
    import alu_issue_pkg::*;

    logic            res_valid;
    cdb_t            res_data;
    logic [xlen-1:0] alu_value;
    logic            issue_fire;

    function automatic logic [xlen-1:0] alu_compute(
        input alu_op_e         op,
        input logic [xlen-1:0] a,
        input logic [xlen-1:0] b
    );
        logic [xlen-1:0] r;
        case (op)
            alu_add: r = a + b;
            alu_sub: r = a - b;
            alu_and: r = a & b;
            alu_or:  r = a | b;
            alu_xor: r = a ^ b;
            alu_sll: r = a << b[4:0];
            alu_srl: r = a >> b[4:0];
            alu_slt: r = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
            default: r = '0;
        endcase
        return r;
    endfunction

    ////////////////////
    // execute
    ////////////////////
    assign alu_value = alu_compute(issue.entry.alu_op,
                                   issue.entry.opa_value,
                                   issue.entry.opb_value);

    assign issue.ready = !res_valid || alu_grant;
    assign issue_fire  = issue.valid && issue.ready;

    ////////////////////
    // result register
    ////////////////////
    always_ff @(posedge clock) begin
        if (reset || flush)
            res_valid <= 1'b0;
        else if (issue_fire)
            res_valid <= 1'b1;
        else if (alu_grant)
            res_valid <= 1'b0;           // drained, nothing new
    end

    always_ff @(posedge clock) begin
        if (issue_fire) begin
            res_data.dest_preg <= issue.entry.dest_preg;
            res_data.value     <= alu_value;
            res_data.rob_idx   <= issue.entry.rob_idx;
        end
    end

    assign result.valid = res_valid;
    assign result.data  = res_data;

endmodule

//--- rtl/alu_issue_pkg.sv
////////////////////
// shared widths, alu operation encoding,
// reservation station entry and cdb broadcast types
////////////////////
package alu_issue_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int xlen     = 32;   // datapath width
    localparam int preg_len = 6;    // physical register tag
    localparam int rob_len  = 5;    // reorder buffer index

    ////////////////////
    // alu operations
    ////////////////////
    // shifts use the low 5 bits of operand b
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_sll = 3'd5,
        alu_srl = 3'd6,
        alu_slt = 3'd7     // signed compare
    } alu_op_e;

    ////////////////////
    // station entry
    ////////////////////
    // while an operand is not ready its value field holds
    // the awaited tag in the low preg_len bits
    typedef struct packed {
        logic                opa_ready;
        logic [xlen-1:0]     opa_value;
        logic                opb_ready;
        logic [xlen-1:0]     opb_value;
        alu_op_e             alu_op;
        logic [preg_len-1:0] dest_preg;
        logic [rob_len-1:0]  rob_idx;
    } rs_entry_t;

    ////////////////////
    // cdb broadcast
    ////////////////////
    typedef struct packed {
        logic [preg_len-1:0] dest_preg;   // tag being produced
        logic [xlen-1:0]     value;
        logic [rob_len-1:0]  rob_idx;
    } cdb_t;

endpackage

//--- rtl/alu_issue_top.sv
////////////////////
// alu issue cluster top level
// station, alu and cdb arbiter on plain ports
////////////////////
`timescale 1ns/1ns

module alu_issue_top #(
    parameter int rs_size = 8
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               flush,
    // dispatch
    input  logic                               dispatch_valid,
    output logic                               rs_full,
    input  logic                               opa_ready,
    input  logic [alu_issue_pkg::xlen-1:0]     opa_value,
    input  logic [alu_issue_pkg::preg_len-1:0] opa_tag,
    input  logic                               opb_ready,
    input  logic [alu_issue_pkg::xlen-1:0]     opb_value,
    input  logic [alu_issue_pkg::preg_len-1:0] opb_tag,
    input  alu_issue_pkg::alu_op_e             alu_op,
    input  logic [alu_issue_pkg::preg_len-1:0] dest_preg,
    input  logic [alu_issue_pkg::rob_len-1:0]  rob_idx,
    // results from other units
    input  logic                               ext_cdb_valid,
    input  logic [alu_issue_pkg::preg_len-1:0] ext_cdb_preg,
    input  logic [alu_issue_pkg::xlen-1:0]     ext_cdb_value,
    input  logic [alu_issue_pkg::rob_len-1:0]  ext_cdb_rob,
    // broadcast
    output logic                               cdb_valid,
    output logic [alu_issue_pkg::preg_len-1:0] cdb_preg,
    output logic [alu_issue_pkg::xlen-1:0]     cdb_value,
    output logic [alu_issue_pkg::rob_len-1:0]  cdb_rob
);
    import alu_issue_pkg::*;

    cdb_t ext_data;
    logic alu_grant;

    issue_if issue_bus ();
    cdb_if   alu_cdb ();      // alu result to arbiter
    cdb_if   bcast_cdb ();    // arbiter to station and outputs

    assign ext_data.dest_preg = ext_cdb_preg;
    assign ext_data.value     = ext_cdb_value;
    assign ext_data.rob_idx   = ext_cdb_rob;

    rs_alu #(.rs_size(rs_size)) u_rs_alu (
        .clock(clock), .reset(reset), .flush(flush),
        .dispatch_valid(dispatch_valid),
        .opa_ready(opa_ready), .opa_value(opa_value), .opa_tag(opa_tag),
        .opb_ready(opb_ready), .opb_value(opb_value), .opb_tag(opb_tag),
        .alu_op(alu_op), .dest_preg(dest_preg), .rob_idx(rob_idx),
        .rs_full(rs_full), .issue(issue_bus), .cdb(bcast_cdb)
    );

    alu_exec u_alu_exec (
        .clock(clock), .reset(reset), .flush(flush),
        .issue(issue_bus), .result(alu_cdb), .alu_grant(alu_grant)
    );

    cdb_arb u_cdb_arb (
        .clock(clock), .reset(reset), .flush(flush),
        .ext_valid(ext_cdb_valid), .ext_data(ext_data),
        .alu_result(alu_cdb), .alu_grant(alu_grant), .bcast(bcast_cdb)
    );

    assign cdb_valid = bcast_cdb.valid;
    assign cdb_preg  = bcast_cdb.data.dest_preg;
    assign cdb_value = bcast_cdb.data.value;
    assign cdb_rob   = bcast_cdb.data.rob_idx;

endmodule

//--- rtl/cdb_arb.sv
////////////////////
// cdb arbiter
// external result first, alu result otherwise
////////////////////
`timescale 1ns/1ns

module cdb_arb (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  logic                ext_valid,
    input  alu_issue_pkg::cdb_t ext_data,
    cdb_if.dst                  alu_result,
    output logic                alu_grant,
    cdb_if.src                  bcast
);
    import alu_issue_pkg::*;

    logic bcast_valid;
    cdb_t bcast_data;

    // alu only wins an otherwise idle bus
    assign alu_grant = alu_result.valid && !ext_valid;

    ////////////////////
    // broadcast register
    ////////////////////
    always_ff @(posedge clock) begin
        if (reset || flush)
            bcast_valid <= 1'b0;
        else
            bcast_valid <= ext_valid || alu_result.valid;
    end

    always_ff @(posedge clock) begin
        if (ext_valid)
            bcast_data <= ext_data;
        else if (alu_grant)
            bcast_data <= alu_result.data;
    end

    assign bcast.valid = bcast_valid;
    assign bcast.data  = bcast_data;

endmodule

//--- rtl/cdb_if.sv
////////////////////
// one cdb broadcast
// valid plus payload, no back-pressure
////////////////////
`timescale 1ns/1ns

interface cdb_if;
    import alu_issue_pkg::*;

    logic valid;
    cdb_t data;

    // producer side
    modport src (
        output valid,
        output data
    );

    // consumer side
    modport dst (
        input valid,
        input data
    );

endinterface

//--- rtl/issue_if.sv
////////////////////
// issue channel from the reservation
// station to the alu
////////////////////
`timescale 1ns/1ns

interface issue_if;
    import alu_issue_pkg::*;

    logic      valid;
    logic      ready;
    rs_entry_t entry;   // held while valid && !ready

    modport rs (
        output valid,
        output entry,
        input  ready
    );

    modport alu (
        input  valid,
        input  entry,
        output ready
    );

endinterface

//--- rtl/psel_gen.sv
////////////////////
// fixed priority selector
// lowest index wins
////////////////////
`timescale 1ns/1ns

module psel_gen #(
    parameter  int width = 8,
    localparam int idx_w = (width > 1) ? $clog2(width) : 1
) (
    input  logic [width-1:0] req,
    output logic [width-1:0] gnt,       // one-hot
    output logic [idx_w-1:0] gnt_idx,
    output logic             empty      // nothing requested
);

    // scan from the top so the lowest request is the last one written
    always_comb begin
        gnt     = '0;
        gnt_idx = '0;
        for (int i = width - 1; i >= 0; i--) begin
            if (req[i]) begin
                gnt     = '0;
                gnt[i]  = 1'b1;
                gnt_idx = i[idx_w-1:0];
            end
        end
    end

    assign empty = ~|req;

endmodule

//--- rtl/rs_alu.sv
////////////////////
// alu reservation station
// dispatch into the lowest free slot, cdb wakeup,
// oldest-index select and issue register
////////////////////
`timescale 1ns/1ns

module rs_alu #(
    parameter int rs_size = 8
) (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               flush,
    // dispatch
    input  logic                               dispatch_valid,
    input  logic                               opa_ready,
    input  logic [alu_issue_pkg::xlen-1:0]     opa_value,
    input  logic [alu_issue_pkg::preg_len-1:0] opa_tag,
    input  logic                               opb_ready,
    input  logic [alu_issue_pkg::xlen-1:0]     opb_value,
    input  logic [alu_issue_pkg::preg_len-1:0] opb_tag,
    input  alu_issue_pkg::alu_op_e             alu_op,
    input  logic [alu_issue_pkg::preg_len-1:0] dest_preg,
    input  logic [alu_issue_pkg::rob_len-1:0]  rob_idx,
    output logic                               rs_full,
    // issue and wakeup
    issue_if.rs                                issue,
    cdb_if.dst                                 cdb
);
    import alu_issue_pkg::*;

    localparam int idx_w = (rs_size > 1) ? $clog2(rs_size) : 1;

    rs_entry_t          entries [rs_size];
    rs_entry_t          woken   [rs_size];   // entries with this cycle's broadcast applied
    rs_entry_t          disp_entry;
    logic [rs_size-1:0] free;
    logic [rs_size-1:0] free_gnt;
    logic [idx_w-1:0]   free_idx;
    logic [rs_size-1:0] req;
    logic [rs_size-1:0] sel_gnt;
    logic [idx_w-1:0]   sel_idx;
    logic               sel_empty;
    logic               opa_hit;
    logic               opb_hit;
    logic               dispatch_fire;
    logic               can_issue;
    logic               issue_fire;
    logic               issue_valid;
    rs_entry_t          issue_entry;

    ////////////////////
    // dispatch
    ////////////////////
    // a waiting operand whose tag is on the cdb right now is taken as ready
    assign opa_hit = !opa_ready && cdb.valid && (opa_tag == cdb.data.dest_preg);
    assign opb_hit = !opb_ready && cdb.valid && (opb_tag == cdb.data.dest_preg);

    always_comb begin
        disp_entry.opa_ready = opa_ready || opa_hit;
        if (opa_ready)
            disp_entry.opa_value = opa_value;
        else if (opa_hit)
            disp_entry.opa_value = cdb.data.value;
        else
            disp_entry.opa_value = xlen'(opa_tag);
        disp_entry.opb_ready = opb_ready || opb_hit;
        if (opb_ready)
            disp_entry.opb_value = opb_value;
        else if (opb_hit)
            disp_entry.opb_value = cdb.data.value;
        else
            disp_entry.opb_value = xlen'(opb_tag);
        disp_entry.alu_op    = alu_op;
        disp_entry.dest_preg = dest_preg;
        disp_entry.rob_idx   = rob_idx;
    end

    // free slot finder, empty means no free slot left
    psel_gen #(.width(rs_size)) u_free_sel (
        .req     (free),
        .gnt     (free_gnt),
        .gnt_idx (free_idx),
        .empty   (rs_full)
    );

    assign dispatch_fire = dispatch_valid && !rs_full;

    ////////////////////
    // wakeup
    ////////////////////
    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            woken[i] = entries[i];
            if (cdb.valid && !entries[i].opa_ready &&
                entries[i].opa_value[preg_len-1:0] == cdb.data.dest_preg) begin
                woken[i].opa_ready = 1'b1;
                woken[i].opa_value = cdb.data.value;
            end
            if (cdb.valid && !entries[i].opb_ready &&
                entries[i].opb_value[preg_len-1:0] == cdb.data.dest_preg) begin
                woken[i].opb_ready = 1'b1;
                woken[i].opb_value = cdb.data.value;
            end
            req[i] = !free[i] && woken[i].opa_ready && woken[i].opb_ready;
        end
    end

    ////////////////////
    // select and issue
    ////////////////////
    psel_gen #(.width(rs_size)) u_issue_sel (
        .req     (req),
        .gnt     (sel_gnt),
        .gnt_idx (sel_idx),
        .empty   (sel_empty)
    );

    assign can_issue  = !issue_valid || issue.ready;   // issue reg empty or draining
    assign issue_fire = can_issue && !sel_empty;

    always_ff @(posedge clock) begin
        if (reset || flush)
            issue_valid <= 1'b0;
        else if (can_issue)
            issue_valid <= !sel_empty;
    end

    always_ff @(posedge clock) begin
        if (issue_fire)
            issue_entry <= woken[sel_idx];
    end

    assign issue.valid = issue_valid;
    assign issue.entry = issue_entry;

    ////////////////////
    // entry storage
    ////////////////////
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_size; i++)
            entries[i] <= woken[i];
        if (dispatch_fire)
            entries[free_idx] <= disp_entry;   // new entry overrides its slot
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            free <= '1;
        end else begin
            for (int i = 0; i < rs_size; i++) begin
                if (dispatch_fire && free_gnt[i])
                    free[i] <= 1'b0;
                else if (issue_fire && sel_gnt[i])
                    free[i] <= 1'b1;       // slot released on issue
            end
        end
    end

endmodule

//--- verification/tb_alu_issue.sv
////////////////////
// directed testbench for the alu issue cluster
// reference alu model, cdb collector, compare tasks and tests
////////////////////
`timescale 1ns/1ns

module tb_alu_issue;
    import alu_issue_pkg::*;

    localparam int timeout_cycles = 60;

    logic                clock = 1'b0;
    logic                reset;
    logic                flush;
    logic                dispatch_valid;
    logic                rs_full;
    logic                opa_ready;
    logic [xlen-1:0]     opa_value;
    logic [preg_len-1:0] opa_tag;
    logic                opb_ready;
    logic [xlen-1:0]     opb_value;
    logic [preg_len-1:0] opb_tag;
    alu_op_e             alu_op;
    logic [preg_len-1:0] dest_preg;
    logic [rob_len-1:0]  rob_idx;
    logic                ext_cdb_valid;
    logic [preg_len-1:0] ext_cdb_preg;
    logic [xlen-1:0]     ext_cdb_value;
    logic [rob_len-1:0]  ext_cdb_rob;
    logic                cdb_valid;
    logic [preg_len-1:0] cdb_preg;
    logic [xlen-1:0]     cdb_value;
    logic [rob_len-1:0]  cdb_rob;

    int   seed = 42;
    int   cycle_cnt = 0;      // posedges seen so far
    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    cdb_t got_q [$];          // broadcasts in arrival order
    int   got_cyc_q [$];      // edge at which each one went valid

    alu_issue_top #(.rs_size(8)) u_dut (.*);

    always #4 clock = ~clock;   // 8 ns period

    always @(posedge clock) cycle_cnt <= cycle_cnt + 1;

    // outputs only move at the rising edge, so the falling edge sees them settled
    always @(negedge clock) begin
        if (cdb_valid === 1'b1) begin
            got_q.push_back(make_cdb(cdb_preg, cdb_value, cdb_rob));
            got_cyc_q.push_back(cycle_cnt);
        end
    end

    ////////////////////
    // reference model
    ////////////////////
    function automatic logic [xlen-1:0] ref_alu(
        input alu_op_e         op,
        input logic [xlen-1:0] a,
        input logic [xlen-1:0] b
    );
        logic [4:0] sh;
        sh = b[4:0];               // shift amount from low bits only
        case (op)
            alu_add: return a + b;
            alu_sub: return a + ~b + 1'b1;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_sll: return a << sh;
            alu_srl: return a >> sh;
            alu_slt: begin
                // differing signs decide on their own
                if (a[xlen-1] != b[xlen-1])
                    return {{(xlen-1){1'b0}}, a[xlen-1]};
                return {{(xlen-1){1'b0}}, (a < b)};
            end
            default: return '0;
        endcase
    endfunction

    function automatic cdb_t make_cdb(
        input logic [preg_len-1:0] preg,
        input logic [xlen-1:0]     value,
        input logic [rob_len-1:0]  rob
    );
        cdb_t c;
        c.dest_preg = preg;
        c.value     = value;
        c.rob_idx   = rob;
        return c;
    endfunction

    ////////////////////
    // checks
    ////////////////////
    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic check_cdb(input cdb_t got, input cdb_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %0d/%h/%0d expected %0d/%h/%0d (preg/value/rob)",
                     $time, what, got.dest_preg, got.value, got.rob_idx,
                     exp.dest_preg, exp.value, exp.rob_idx);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////
    // called at a falling edge, returns at the falling edge after acceptance
    task automatic dispatch_op(
        input  alu_op_e             op,
        input  logic                a_rdy,
        input  logic [xlen-1:0]     a,        // value, or tag when not ready
        input  logic                b_rdy,
        input  logic [xlen-1:0]     b,
        input  logic [preg_len-1:0] dest,
        input  logic [rob_len-1:0]  rob,
        output int                  edge_no
    );
        int waited = 0;
        while (rs_full !== 1'b0 && waited < timeout_cycles) begin
            @(negedge clock);
            waited++;
        end
        if (rs_full !== 1'b0)
            report_error("station stayed full, dispatch was not accepted");
        dispatch_valid = 1'b1;
        alu_op    = op;
        opa_ready = a_rdy;
        opa_value = a;
        opa_tag   = a[preg_len-1:0];
        opb_ready = b_rdy;
        opb_value = b;
        opb_tag   = b[preg_len-1:0];
        dest_preg = dest;
        rob_idx   = rob;
        edge_no   = cycle_cnt + 1;     // the coming rising edge
        @(negedge clock);
        dispatch_valid = 1'b0;
    endtask

    task automatic send_ext(
        input logic [preg_len-1:0] preg,
        input logic [xlen-1:0]     value,
        input logic [rob_len-1:0]  rob
    );
        ext_cdb_valid = 1'b1;
        ext_cdb_preg  = preg;
        ext_cdb_value = value;
        ext_cdb_rob   = rob;
        @(negedge clock);
        ext_cdb_valid = 1'b0;
    endtask

    // next broadcast against an expected one, cyc is its valid edge
    task automatic expect_next(input cdb_t exp, input string what, output int cyc);
        int waited = 0;
        while (got_q.size() == 0 && waited < timeout_cycles) begin
            @(posedge clock);
            waited++;
        end
        cyc = -1;
        if (got_q.size() == 0) begin
            report_error($sformatf("no cdb broadcast arrived in time for %s", what));
        end else begin
            cyc = got_cyc_q.pop_front();
            check_cdb(got_q.pop_front(), exp, what);
        end
        @(negedge clock);
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        repeat (cycles) @(posedge clock);
        if (got_q.size() != 0)
            report_error($sformatf("%0d unexpected cdb broadcasts, %s", got_q.size(), what));
        @(negedge clock);
    endtask

    task automatic clear_results();
        got_q.delete();
        got_cyc_q.delete();
    endtask

    ////////////////////
    // tests
    ////////////////////
    task automatic ready_path();
        logic [xlen-1:0] a_val [8];
        logic [xlen-1:0] b_val [8];
        int              edge_no [8];
        int              cyc;
        int              err_before;
        err_before = errors;
        clear_results();
        for (int i = 0; i < 8; i++) begin
            a_val[i] = $random(seed);
            b_val[i] = $random(seed);
            dispatch_op(alu_op_e'(3'(i)), 1'b1, a_val[i], 1'b1, b_val[i],
                        preg_len'(8 + i), rob_len'(i), edge_no[i]);
        end
        for (int i = 0; i < 8; i++) begin
            expect_next(make_cdb(preg_len'(8 + i), ref_alu(alu_op_e'(3'(i)), a_val[i], b_val[i]),
                                 rob_len'(i)), "ready operand result", cyc);
            if (i == 0 && cyc != edge_no[0] + 3) begin
                errors++;
                $display("mismatch at %0t: first result latency %0d cycles, expected 3",
                         $time, cyc - edge_no[0]);
            end
        end
        end_test("ready-operand path", err_before);
    endtask

    task automatic wakeup_from_ext();
        logic [xlen-1:0] va;
        logic [xlen-1:0] vb;
        int              edge_no;
        int              cyc;
        int              err_before;
        err_before = errors;
        clear_results();
        va = $random(seed);
        vb = $random(seed);
        dispatch_op(alu_add, 1'b0, xlen'(40), 1'b1, vb, 6'd20, 5'd10, edge_no);
        expect_quiet(6, "while the operand is still waiting");
        send_ext(6'd40, va, 5'd11);
        expect_next(make_cdb(6'd40, va, 5'd11), "external wakeup broadcast", cyc);
        expect_next(make_cdb(6'd20, ref_alu(alu_add, va, vb), 5'd10), "woken result", cyc);
        end_test("wakeup", err_before);
    endtask

    task automatic dependency_chain();
        logic [xlen-1:0] va;
        logic [xlen-1:0] vb;
        logic [xlen-1:0] vc;
        logic [xlen-1:0] first;
        int              edge_no;
        int              cyc;
        int              err_before;
        err_before = errors;
        clear_results();
        va = $random(seed);
        vb = $random(seed);
        vc = $random(seed);
        first = ref_alu(alu_sub, va, vb);
        dispatch_op(alu_sub, 1'b1, va, 1'b1, vb, 6'd30, 5'd12, edge_no);
        dispatch_op(alu_xor, 1'b0, xlen'(30), 1'b1, vc, 6'd31, 5'd13, edge_no);  // waits on p30
        expect_next(make_cdb(6'd30, first, 5'd12), "chain producer", cyc);
        expect_next(make_cdb(6'd31, ref_alu(alu_xor, first, vc), 5'd13), "chain consumer", cyc);
        end_test("dependency chain", err_before);
    endtask

    task automatic full_then_flush();
        logic [xlen-1:0] ext_v;
        int              edge_no;
        int              cyc;
        int              err_before;
        err_before = errors;
        clear_results();
        ext_v = $random(seed);
        for (int i = 0; i < 8; i++)
            dispatch_op(alu_add, 1'b0, xlen'(50 + i), 1'b0, xlen'(50 + i),
                        preg_len'(i), rob_len'(i), edge_no);
        check_flag(rs_full, 1'b1, "rs_full after eight waiting dispatches");
        // an external result arriving with the flush is dropped with it
        flush = 1'b1;
        send_ext(6'd50, ext_v, 5'd30);
        flush = 1'b0;
        check_flag(rs_full, 1'b0, "rs_full after flush");
        check_flag(cdb_valid, 1'b0, "cdb_valid after flush");
        // tag of a flushed entry, must wake nothing
        send_ext(6'd51, ext_v, 5'd31);
        expect_next(make_cdb(6'd51, ext_v, 5'd31), "external broadcast after flush", cyc);
        expect_quiet(10, "after the flush");
        end_test("full and flush", err_before);
    endtask

    task automatic cdb_contention();
        logic [xlen-1:0] a [3];
        logic [xlen-1:0] b [3];
        logic [xlen-1:0] ev [4];
        alu_op_e         ops [3];
        int              edge_no;
        int              cyc;
        int              err_before;
        err_before = errors;
        clear_results();
        ops[0] = alu_add;
        ops[1] = alu_or;
        ops[2] = alu_slt;
        for (int i = 0; i < 3; i++) begin
            a[i] = $random(seed);
            b[i] = $random(seed);
            dispatch_op(ops[i], 1'b1, a[i], 1'b1, b[i], preg_len'(33 + i), rob_len'(20 + i), edge_no);
        end
        // external results hold the bus while the alu results are pending
        for (int i = 0; i < 4; i++) begin
            ev[i] = $random(seed);
            send_ext(preg_len'(44 + i), ev[i], rob_len'(24 + i));
        end
        for (int i = 0; i < 4; i++)
            expect_next(make_cdb(preg_len'(44 + i), ev[i], rob_len'(24 + i)),
                        "external result under contention", cyc);
        for (int i = 0; i < 3; i++)
            expect_next(make_cdb(preg_len'(33 + i), ref_alu(ops[i], a[i], b[i]), rob_len'(20 + i)),
                        "alu result after contention", cyc);
        expect_quiet(8, "duplicate results after contention");
        end_test("cdb contention", err_before);
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial begin
        reset          = 1'b1;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        opa_ready      = 1'b0;
        opa_value      = '0;
        opa_tag        = '0;
        opb_ready      = 1'b0;
        opb_value      = '0;
        opb_tag        = '0;
        alu_op         = alu_add;
        dest_preg      = '0;
        rob_idx        = '0;
        ext_cdb_valid  = 1'b0;
        ext_cdb_preg   = '0;
        ext_cdb_value  = '0;
        ext_cdb_rob    = '0;
        repeat (5) @(negedge clock);     // five rising edges in reset
        reset = 1'b0;
        @(negedge clock);
        ready_path();
        wakeup_from_ext();
        dependency_chain();
        full_then_flush();
        cdb_contention();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

    // guards against a hang anywhere above
    initial begin
        #20000;
        $display("simulation ran too long, the tests did not finish");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
